// ==== ant_config.svh ====
`ifndef ANT_CONFIG_SVH
`define ANT_CONFIG_SVH

// Screen size in pixels
`define ANT_SCREEN_WIDTH  160
`define ANT_SCREEN_HEIGHT 120

// Ant rectangle
`define ANT_WIDTH  4
`define ANT_HEIGHT 4

// Food items visited by one update scan
`define ANT_NUM_FOOD 4

// Field widths
`define ANT_X_WIDTH  8
`define ANT_Y_WIDTH  7
`define ANT_ID_WIDTH 6

// Pixel colour
`define ANT_COLOUR_WIDTH 3
`define ANT_COLOUR       3'd4

// Datapath port
`define DP_ADDR_WIDTH   8
`define DP_RESULT_WIDTH 16
`define DP_INSTR_WIDTH  32

`endif

// ==== ant_draw.sv ====
`timescale 1ns/1ps
`include "ant_config.svh"

module ant_draw
    import ant_field_pkg::*, dp_isa_pkg::*;
(
    input  logic    clock,
    input  logic    resetn,
    input  logic    go,
    input  ant_id_t ant_id,
    output logic    done,
    dp_if.requester dp
);

    typedef enum logic [1:0] {
        IDLE,
        READ_X,
        READ_Y,
        PLOT
    } draw_state_t;

    draw_state_t state;
    logic        req_q;
    logic [$clog2(`ANT_WIDTH)-1:0]  dx;
    logic [$clog2(`ANT_HEIGHT)-1:0] dy;
    logic        last_pixel;
    ant_id_t     id_q;
    coord_x_t    base_x;
    coord_y_t    base_y;
    logic        rq_done;
    dp_result_t  rq_result;
    dp_instr_t   instr_next;

    dp_requester u_requester (
        .clock    (clock),
        .resetn   (resetn),
        .request  (req_q),
        .instr_in (instr_next),
        .done     (rq_done),
        .result   (rq_result),
        .port     (dp)
    );

    assign last_pixel = (dx == `ANT_WIDTH - 1) && (dy == `ANT_HEIGHT - 1);

    always_ff @(posedge clock) begin
        if (!resetn) begin
            state <= IDLE;
            req_q <= 1'b0;
            dx    <= '0;
            dy    <= '0;
        end else begin
            req_q <= 1'b0;
            case (state)
                IDLE: begin
                    if (go) begin
                        state <= READ_X;
                        req_q <= 1'b1;
                        dx    <= '0;
                        dy    <= '0;
                    end
                end
                READ_X, READ_Y: begin
                    if (rq_done) begin
                        state <= draw_state_t'(state + 1'b1);
                        req_q <= 1'b1;
                    end
                end
                PLOT: begin
                    // Row by row, dx fastest
                    if (rq_done) begin
                        if (last_pixel) begin
                            state <= IDLE;
                        end else begin
                            req_q <= 1'b1;
                            dx    <= dx + 1'b1;
                            if (dx == `ANT_WIDTH - 1) begin
                                dx <= '0;
                                dy <= dy + 1'b1;
                            end
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Rectangle origin sits one pixel up and left of the stored position
    always_ff @(posedge clock) begin
        if (state == IDLE && go) begin
            id_q <= ant_id;
        end
        if (rq_done && state == READ_X) begin
            base_x <= coord_x_t'(rq_result) - 1'b1;
        end
        if (rq_done && state == READ_Y) begin
            base_y <= coord_y_t'(rq_result) - 1'b1;
        end
    end

    always_comb begin
        case (state)
            READ_X:  instr_next = dp_read(ANT_X_BASE + dp_addr_t'(id_q));
            READ_Y:  instr_next = dp_read(ANT_Y_BASE + dp_addr_t'(id_q));
            PLOT:    instr_next = dp_draw(base_x + coord_x_t'(dx), base_y + coord_y_t'(dy),
                                          ANT_INK, 1'b1);
            default: instr_next = '0;
        endcase
    end

    assign done = rq_done && (state == PLOT) && last_pixel;

endmodule

// ==== ant_engine.f ====
+incdir+.
ant_field_pkg.sv
dp_isa_pkg.sv
dp_if.sv
dp_requester.sv
ant_update.sv
ant_draw.sv
dp_arbiter.sv
ant_engine.sv
tb_datapath_model.sv
tb_ant_engine.sv

// ==== ant_engine.sv ====
`timescale 1ns/1ps

module ant_engine
    import ant_field_pkg::*, dp_isa_pkg::*;
(
    input  logic       clock,
    input  logic       resetn,
    input  logic       start_update,
    input  logic       start_draw,
    input  ant_id_t    ant_id,
    input  logic       finished_dp,
    input  dp_result_t result_dp,
    output logic       finished,
    output logic       start_dp,
    output dp_instr_t  instruction_dp
);

    logic update_go;
    logic draw_go;
    logic update_done;
    logic draw_done;

    dp_if u_update_if ();
    dp_if u_draw_if ();

    dp_arbiter u_arbiter (
        .clock          (clock),
        .resetn         (resetn),
        .start_update   (start_update),
        .start_draw     (start_draw),
        .finished_dp    (finished_dp),
        .result_dp      (result_dp),
        .update_done    (update_done),
        .draw_done      (draw_done),
        .finished       (finished),
        .update_go      (update_go),
        .draw_go        (draw_go),
        .start_dp       (start_dp),
        .instruction_dp (instruction_dp),
        .update_port    (u_update_if.arbiter),
        .draw_port      (u_draw_if.arbiter)
    );

    ant_update u_update (
        .clock  (clock),
        .resetn (resetn),
        .go     (update_go),
        .ant_id (ant_id),
        .done   (update_done),
        .dp     (u_update_if.requester)
    );

    ant_draw u_draw (
        .clock  (clock),
        .resetn (resetn),
        .go     (draw_go),
        .ant_id (ant_id),
        .done   (draw_done),
        .dp     (u_draw_if.requester)
    );

endmodule

// ==== ant_field_pkg.sv ====
`include "ant_config.svh"

package ant_field_pkg;

    // Screen coordinates
    typedef logic [`ANT_X_WIDTH-1:0] coord_x_t;
    typedef logic [`ANT_Y_WIDTH-1:0] coord_y_t;

    // Ant and food indices
    typedef logic [`ANT_ID_WIDTH-1:0] ant_id_t;
    typedef logic [$clog2(`ANT_NUM_FOOD)-1:0] food_idx_t;

    // Manhattan distance, one bit wider than the widest coordinate
    typedef logic [`ANT_X_WIDTH:0] distance_t;

    // Start value of the nearest-food search
    localparam distance_t DIST_FAR = '1;

    typedef logic [`ANT_COLOUR_WIDTH-1:0] colour_t;

    localparam colour_t ANT_INK = `ANT_COLOUR;

    // Last food index of a scan
    localparam food_idx_t LAST_FOOD = food_idx_t'(`ANT_NUM_FOOD - 1);

endpackage

// ==== ant_update.sv ====
`timescale 1ns/1ps
`include "ant_config.svh"

module ant_update
    import ant_field_pkg::*, dp_isa_pkg::*;
(
    input  logic    clock,
    input  logic    resetn,
    input  logic    go,
    input  ant_id_t ant_id,
    output logic    done,
    dp_if.requester dp
);

    // Movement margins
    localparam coord_x_t X_HI = coord_x_t'(`ANT_SCREEN_WIDTH - `ANT_WIDTH / 2 - 1);
    localparam coord_y_t Y_HI = coord_y_t'(`ANT_SCREEN_HEIGHT - `ANT_HEIGHT / 2 - 1);
    localparam coord_x_t X_LO = coord_x_t'(`ANT_WIDTH / 2);
    localparam coord_y_t Y_LO = coord_y_t'(`ANT_HEIGHT / 2);

    typedef enum logic [2:0] {
        IDLE,
        READ_X,
        READ_Y,
        FOOD_X,
        FOOD_Y,
        WRITE_X,
        WRITE_Y
    } upd_state_t;

    upd_state_t state;
    logic       req_q;
    food_idx_t  food_idx;
    ant_id_t    id_q;
    coord_x_t   ant_x, food_x, near_x, next_x;
    coord_y_t   ant_y, near_y, next_y;
    distance_t  near_dist;

    logic       rq_done;
    dp_result_t rq_result;
    dp_instr_t  instr_next;
    coord_y_t   food_y_in;
    coord_x_t   dist_x;
    coord_y_t   dist_y;
    distance_t  food_dist;

    dp_requester u_requester (
        .clock    (clock),
        .resetn   (resetn),
        .request  (req_q),
        .instr_in (instr_next),
        .done     (rq_done),
        .result   (rq_result),
        .port     (dp)
    );

    // req_q pulses on entry to each transaction step
    always_ff @(posedge clock) begin
        if (!resetn) begin
            state    <= IDLE;
            req_q    <= 1'b0;
            food_idx <= '0;
        end else begin
            req_q <= 1'b0;
            case (state)
                IDLE: begin
                    if (go) begin
                        state    <= READ_X;
                        req_q    <= 1'b1;
                        food_idx <= '0;
                    end
                end
                FOOD_Y: begin
                    if (rq_done) begin
                        req_q <= 1'b1;
                        if (food_idx == LAST_FOOD) begin
                            state <= WRITE_X;
                        end else begin
                            food_idx <= food_idx + 1'b1;
                            state    <= FOOD_X;
                        end
                    end
                end
                WRITE_Y: begin
                    if (rq_done) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    if (rq_done) begin
                        state <= upd_state_t'(state + 1'b1);
                        req_q <= 1'b1;
                    end
                end
            endcase
        end
    end

    assign food_y_in = coord_y_t'(rq_result);
    assign dist_x    = (food_x > ant_x) ? food_x - ant_x : ant_x - food_x;
    assign dist_y    = (food_y_in > ant_y) ? food_y_in - ant_y : ant_y - food_y_in;
    assign food_dist = distance_t'(dist_x) + distance_t'(dist_y);

    always_ff @(posedge clock) begin
        if (state == IDLE && go) begin
            id_q      <= ant_id;
            near_dist <= DIST_FAR;
        end
        if (rq_done) begin
            case (state)
                READ_X: ant_x  <= coord_x_t'(rq_result);
                READ_Y: ant_y  <= coord_y_t'(rq_result);
                FOOD_X: food_x <= coord_x_t'(rq_result);
                FOOD_Y: begin
                    // Strictly smaller, so a tie keeps the lower index
                    if (food_dist < near_dist) begin
                        near_x    <= food_x;
                        near_y    <= food_y_in;
                        near_dist <= food_dist;
                    end
                end
                default: ;
            endcase
        end
    end

    // One step toward the nearest food on each axis
    always_comb begin
        next_x = ant_x;
        next_y = ant_y;
        if (near_x > ant_x && ant_x < X_HI) begin
            next_x = ant_x + 1'b1;
        end else if (near_x < ant_x && ant_x > X_LO) begin
            next_x = ant_x - 1'b1;
        end
        if (near_y > ant_y && ant_y < Y_HI) begin
            next_y = ant_y + 1'b1;
        end else if (near_y < ant_y && ant_y > Y_LO) begin
            next_y = ant_y - 1'b1;
        end
    end

    always_comb begin
        case (state)
            READ_X:  instr_next = dp_read(ANT_X_BASE + dp_addr_t'(id_q));
            READ_Y:  instr_next = dp_read(ANT_Y_BASE + dp_addr_t'(id_q));
            FOOD_X:  instr_next = dp_read(FOOD_X_BASE + dp_addr_t'(food_idx));
            FOOD_Y:  instr_next = dp_read(FOOD_Y_BASE + dp_addr_t'(food_idx));
            WRITE_X: instr_next = dp_write(ANT_X_BASE + dp_addr_t'(id_q), dp_result_t'(next_x));
            WRITE_Y: instr_next = dp_write(ANT_Y_BASE + dp_addr_t'(id_q), dp_result_t'(next_y));
            default: instr_next = '0;
        endcase
    end

    assign done = rq_done && (state == WRITE_Y);

    a_food_idx_range: assert property (@(posedge clock) disable iff (!resetn)
        (state == FOOD_X || state == FOOD_Y) |-> (food_idx <= LAST_FOOD));

endmodule

// ==== dp_arbiter.sv ====
`timescale 1ns/1ps

module dp_arbiter
    import dp_isa_pkg::*;
(
    input  logic       clock,
    input  logic       resetn,
    input  logic       start_update,
    input  logic       start_draw,
    input  logic       finished_dp,
    input  dp_result_t result_dp,
    input  logic       update_done,
    input  logic       draw_done,
    output logic       finished,
    output logic       update_go,
    output logic       draw_go,
    output logic       start_dp,
    output dp_instr_t  instruction_dp,
    dp_if.arbiter      update_port,
    dp_if.arbiter      draw_port
);

    logic busy;
    logic owner_update;
    logic owner_done;

    assign owner_done = owner_update ? update_done : draw_done;

    // High again in the same cycle as the owner's last done
    assign finished = !busy || owner_done;

    always_ff @(posedge clock) begin
        if (!resetn) begin
            busy         <= 1'b0;
            owner_update <= 1'b0;
            update_go    <= 1'b0;
            draw_go      <= 1'b0;
        end else begin
            update_go <= 1'b0;
            draw_go   <= 1'b0;
            if (finished) begin
                // Update has priority when both strobes arrive together
                if (start_update) begin
                    busy         <= 1'b1;
                    owner_update <= 1'b1;
                    update_go    <= 1'b1;
                end else if (start_draw) begin
                    busy         <= 1'b1;
                    owner_update <= 1'b0;
                    draw_go      <= 1'b1;
                end else begin
                    busy <= 1'b0;
                end
            end
        end
    end

    // Outside port follows the owner, idle value is zero
    assign start_dp = busy && (owner_update ? update_port.start : draw_port.start);
    assign instruction_dp = !busy ? '0 :
                            owner_update ? update_port.instr : draw_port.instr;

    assign update_port.finished = busy && owner_update && finished_dp;
    assign update_port.result   = owner_update ? result_dp : '0;
    assign draw_port.finished   = busy && !owner_update && finished_dp;
    assign draw_port.result     = owner_update ? '0 : result_dp;

    a_go_exclusive: assert property (@(posedge clock) disable iff (!resetn)
        !(update_go && draw_go));

    // Datapath only answers a transaction that some command started
    a_no_stray_finish: assert property (@(posedge clock) disable iff (!resetn)
        finished_dp |-> busy);

endmodule

// ==== dp_if.sv ====
`timescale 1ns/1ps

// One datapath transaction between a controller and the arbiter
interface dp_if
    import dp_isa_pkg::*;
();

    logic       start;
    logic       finished;
    dp_instr_t  instr;
    dp_result_t result;

    modport requester (
        output start,
        output instr,
        input  finished,
        input  result
    );

    modport arbiter (
        input  start,
        input  instr,
        output finished,
        output result
    );

endinterface

// ==== dp_isa_pkg.sv ====
`include "ant_config.svh"

package dp_isa_pkg;

    typedef enum logic [2:0] {
        MEMREAD  = 3'd1,
        MEMWRITE = 3'd2,
        DRAW     = 3'd3
    } dp_opcode_t;

    typedef logic [`DP_ADDR_WIDTH-1:0]   dp_addr_t;
    typedef logic [`DP_RESULT_WIDTH-1:0] dp_result_t;
    typedef logic [`DP_INSTR_WIDTH-1:0]  dp_instr_t;

    // Field positions inside an instruction
    localparam int ADDR_LSB   = 3;
    localparam int DATA_LSB   = ADDR_LSB + `DP_ADDR_WIDTH;
    localparam int DRAW_Y_LSB = ADDR_LSB + `ANT_X_WIDTH;
    localparam int COLOUR_LSB = DRAW_Y_LSB + `ANT_Y_WIDTH;
    localparam int PLOT_BIT   = COLOUR_LSB + `ANT_COLOUR_WIDTH;

    // Memory regions, indexed by ant or food number
    localparam dp_addr_t ANT_X_BASE  = 8'h00;
    localparam dp_addr_t ANT_Y_BASE  = 8'h40;
    localparam dp_addr_t FOOD_X_BASE = 8'h80;
    localparam dp_addr_t FOOD_Y_BASE = 8'hC0;

    function automatic dp_instr_t dp_read(input dp_addr_t addr);
        dp_instr_t instr;
        instr = '0;
        instr[2:0] = MEMREAD;
        instr[ADDR_LSB +: `DP_ADDR_WIDTH] = addr;
        return instr;
    endfunction

    function automatic dp_instr_t dp_write(input dp_addr_t addr, input dp_result_t data);
        dp_instr_t instr;
        instr = '0;
        instr[2:0] = MEMWRITE;
        instr[ADDR_LSB +: `DP_ADDR_WIDTH] = addr;
        instr[DATA_LSB +: `DP_RESULT_WIDTH] = data;
        return instr;
    endfunction

    function automatic dp_instr_t dp_draw(input logic [`ANT_X_WIDTH-1:0] x,
                                          input logic [`ANT_Y_WIDTH-1:0] y,
                                          input logic [`ANT_COLOUR_WIDTH-1:0] colour,
                                          input logic plot);
        dp_instr_t instr;
        instr = '0;
        instr[2:0] = DRAW;
        instr[ADDR_LSB +: `ANT_X_WIDTH] = x;
        instr[DRAW_Y_LSB +: `ANT_Y_WIDTH] = y;
        instr[COLOUR_LSB +: `ANT_COLOUR_WIDTH] = colour;
        instr[PLOT_BIT] = plot;
        return instr;
    endfunction

endpackage

// ==== dp_requester.sv ====
`timescale 1ns/1ps

module dp_requester
    import dp_isa_pkg::*;
(
    input  logic       clock,
    input  logic       resetn,
    input  logic       request,
    input  dp_instr_t  instr_in,
    output logic       done,
    output dp_result_t result,
    dp_if.requester    port
);

    typedef enum logic [1:0] {
        IDLE,
        START,
        HOLD,
        WAIT
    } req_state_t;

    req_state_t state;
    dp_instr_t  instr_q;

    always_ff @(posedge clock) begin
        if (!resetn) begin
            state <= IDLE;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                IDLE: begin
                    if (request) begin
                        state <= START;
                    end
                end
                START: state <= HOLD;
                HOLD:  state <= WAIT;
                WAIT: begin
                    if (port.finished) begin
                        state <= IDLE;
                        done  <= 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Instruction held from request until the datapath answers
    always_ff @(posedge clock) begin
        if (state == IDLE && request) begin
            instr_q <= instr_in;
        end
        if (state == WAIT && port.finished) begin
            result <= port.result;
        end
    end

    assign port.start = (state == START) || (state == HOLD);
    assign port.instr = instr_q;

    // The datapath sees a start strobe of exactly two cycles
    a_start_two_cycles: assert property (@(posedge clock) disable iff (!resetn)
        port.start [*2] |=> !port.start);

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Builds the testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_ant_engine -f ant_engine.f -o tb_ant_engine

status=0
output=$(./obj_dir/tb_ant_engine 2>&1) || status=$?
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx "Result: PASSED"; then
    exit 0
fi
echo "Simulation did not pass, exit status $status"
exit 1

// ==== tb_ant_engine.sv ====
`timescale 1ns/1ps
`include "ant_config.svh"

module tb_ant_engine
    import ant_field_pkg::*, dp_isa_pkg::*;
();

    localparam int SCENARIOS      = 20;
    localparam int TIMEOUT_CYCLES = SCENARIOS * 2 * 24 * 10;
    localparam int X_HI = `ANT_SCREEN_WIDTH - `ANT_WIDTH / 2 - 1;
    localparam int Y_HI = `ANT_SCREEN_HEIGHT - `ANT_HEIGHT / 2 - 1;
    localparam int X_LO = `ANT_WIDTH / 2;
    localparam int Y_LO = `ANT_HEIGHT / 2;

    logic       clock;
    logic       resetn;
    logic       start_update;
    logic       start_draw;
    ant_id_t    ant_id;
    logic       finished_dp;
    dp_result_t result_dp;
    logic       finished;
    logic       start_dp;
    dp_instr_t  instruction_dp;
    logic       load_en;
    dp_addr_t   load_addr;
    dp_result_t load_data;
    logic       protocol_error;

    int          cycle_count = 0;
    int          ant_x;
    int          ant_y;
    int          food_x [`ANT_NUM_FOOD];
    int          food_y [`ANT_NUM_FOOD];
    int          exp_x;
    int          exp_y;
    int          writes_before;
    int          plots_before;
    int          reads_before;

    ant_engine u_dut (
        .clock          (clock),
        .resetn         (resetn),
        .start_update   (start_update),
        .start_draw     (start_draw),
        .ant_id         (ant_id),
        .finished_dp    (finished_dp),
        .result_dp      (result_dp),
        .finished       (finished),
        .start_dp       (start_dp),
        .instruction_dp (instruction_dp)
    );

    tb_datapath_model u_datapath (
        .clock          (clock),
        .resetn         (resetn),
        .start_dp       (start_dp),
        .instruction_dp (instruction_dp),
        .load_en        (load_en),
        .load_addr      (load_addr),
        .load_data      (load_data),
        .finished_dp    (finished_dp),
        .result_dp      (result_dp),
        .protocol_error (protocol_error)
    );

    always #20 clock = ~clock;

    task automatic stop_failed();
        $display("Result: FAILED");
        $fatal(1, "Simulation stopped after a failure");
    endtask

    task automatic report_error(input string msg);
        $display("error %0t: %s", $time, msg);
        stop_failed();
    endtask

    always @(posedge protocol_error) begin
        stop_failed();
    end

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not end within %0d clock cycles", TIMEOUT_CYCLES);
            stop_failed();
        end
    end

    // Random bits above the coordinate are dropped by the engine
    function automatic dp_result_t with_noise(input int coord, input int width);
        dp_result_t noise;
        noise = dp_result_t'($urandom);
        return (noise << width) | dp_result_t'(coord);
    endfunction

    task automatic load_word(input int addr, input dp_result_t data);
        @(posedge clock);
        #1;
        load_en   = 1'b1;
        load_addr = dp_addr_t'(addr);
        load_data = data;
        @(posedge clock);
        #1;
        load_en = 1'b0;
    endtask

    // Kind 1 sets up a distance tie
    // Kind 2 puts the ant at a margin corner
    task automatic make_scenario(input int kind);
        int d;
        @(posedge clock);
        #1;
        ant_id = ant_id_t'($urandom_range(63, 0));
        ant_x  = $urandom_range(X_HI, X_LO);
        ant_y  = $urandom_range(Y_HI, Y_LO);
        for (int k = 0; k < `ANT_NUM_FOOD; k++) begin
            food_x[k] = $urandom_range(`ANT_SCREEN_WIDTH - 1, 0);
            food_y[k] = $urandom_range(`ANT_SCREEN_HEIGHT - 1, 0);
        end
        if (kind == 1) begin
            d = $urandom_range(2, 1);
            food_x[1] = ant_x + d;
            food_y[1] = ant_y;
            food_x[2] = ant_x;
            food_y[2] = ant_y + d;
        end else if (kind == 2) begin
            ant_x = ($urandom_range(1, 0) != 0) ? X_HI : X_LO;
            ant_y = ($urandom_range(1, 0) != 0) ? Y_HI : Y_LO;
            food_x[0] = (ant_x == X_HI) ? `ANT_SCREEN_WIDTH - 1 : 0;
            food_y[0] = (ant_y == Y_HI) ? `ANT_SCREEN_HEIGHT - 1 : 0;
        end
        load_word(int'(ANT_X_BASE) + int'(ant_id), with_noise(ant_x, `ANT_X_WIDTH));
        load_word(int'(ANT_Y_BASE) + int'(ant_id), with_noise(ant_y, `ANT_Y_WIDTH));
        for (int k = 0; k < `ANT_NUM_FOOD; k++) begin
            load_word(int'(FOOD_X_BASE) + k, with_noise(food_x[k], `ANT_X_WIDTH));
            load_word(int'(FOOD_Y_BASE) + k, with_noise(food_y[k], `ANT_Y_WIDTH));
        end
    endtask

    // Nearest food by Manhattan distance
    // The lower index keeps a tie
    function automatic void expected_step(output int nx, output int ny);
        int best;
        int bx;
        int by;
        int d;
        best = 1 << 20;
        bx   = 0;
        by   = 0;
        for (int k = 0; k < `ANT_NUM_FOOD; k++) begin
            d = ((food_x[k] > ant_x) ? food_x[k] - ant_x : ant_x - food_x[k])
              + ((food_y[k] > ant_y) ? food_y[k] - ant_y : ant_y - food_y[k]);
            if (d < best) begin
                best = d;
                bx   = food_x[k];
                by   = food_y[k];
            end
        end
        nx = ant_x;
        ny = ant_y;
        if (bx > ant_x && ant_x < X_HI) nx = ant_x + 1;
        else if (bx < ant_x && ant_x > X_LO) nx = ant_x - 1;
        if (by > ant_y && ant_y < Y_HI) ny = ant_y + 1;
        else if (by < ant_y && ant_y > Y_LO) ny = ant_y - 1;
    endfunction

    task automatic snapshot_logs();
        writes_before = u_datapath.write_count;
        plots_before  = u_datapath.plot_count;
        reads_before  = u_datapath.read_count;
    endtask

    task automatic run_command(input logic do_update, input logic do_draw, input logic poke);
        logic fdp_seen;
        fdp_seen = 1'b0;
        @(posedge clock);
        #1;
        start_update = do_update;
        start_draw   = do_draw;
        @(posedge clock);
        #1;
        start_update = 1'b0;
        start_draw   = 1'b0;
        @(negedge clock);
        assert (!finished) else report_error("finished still high after an accepted strobe");
        if (poke) begin
            // Both strobes while busy are ignored by the engine
            @(posedge clock);
            #1;
            start_update = 1'b1;
            start_draw   = 1'b1;
            @(posedge clock);
            #1;
            start_update = 1'b0;
            start_draw   = 1'b0;
            @(negedge clock);
        end
        while (!finished) begin
            fdp_seen = finished_dp;
            @(negedge clock);
        end
        assert (fdp_seen) else report_error("finished rose without a datapath answer before it");
        repeat (3) begin
            @(negedge clock);
            assert (finished && !start_dp)
                else report_error("engine active without an accepted strobe");
        end
    endtask

    task automatic check_update();
        dp_instr_t w;
        assert (u_datapath.write_count == writes_before + 2 &&
                u_datapath.plot_count == plots_before &&
                u_datapath.read_count == reads_before + 2 + 2 * `ANT_NUM_FOOD)
            else report_error($sformatf("update made %0d writes and %0d plots",
                u_datapath.write_count - writes_before, u_datapath.plot_count - plots_before));
        w = u_datapath.write_log[writes_before % 512];
        assert (w[2:0] == 3'd2 && int'(w[10:3]) == int'(ANT_X_BASE) + int'(ant_id) &&
                int'(w[26:11]) == exp_x)
            else report_error($sformatf("x write %h, expected x %0d", w, exp_x));
        w = u_datapath.write_log[(writes_before + 1) % 512];
        assert (w[2:0] == 3'd2 && int'(w[10:3]) == int'(ANT_Y_BASE) + int'(ant_id) &&
                int'(w[26:11]) == exp_y)
            else report_error($sformatf("y write %h, expected y %0d", w, exp_y));
    endtask

    task automatic check_draw();
        dp_instr_t p;
        int        ex;
        int        ey;
        assert (u_datapath.plot_count == plots_before + `ANT_WIDTH * `ANT_HEIGHT &&
                u_datapath.write_count == writes_before &&
                u_datapath.read_count == reads_before + 2)
            else report_error($sformatf("draw made %0d plots and %0d writes",
                u_datapath.plot_count - plots_before, u_datapath.write_count - writes_before));
        for (int dy = 0; dy < `ANT_HEIGHT; dy++) begin
            for (int dx = 0; dx < `ANT_WIDTH; dx++) begin
                p  = u_datapath.plot_log[(plots_before + dy * `ANT_WIDTH + dx) % 512];
                ex = (exp_x - 1 + dx) & ((1 << `ANT_X_WIDTH) - 1);
                ey = (exp_y - 1 + dy) & ((1 << `ANT_Y_WIDTH) - 1);
                assert (p[2:0] == 3'd3 && int'(p[10:3]) == ex && int'(p[17:11]) == ey &&
                        p[20:18] == 3'd4 && p[21])
                    else report_error($sformatf("plot %h, expected pixel (%0d,%0d)", p, ex, ey));
            end
        end
    endtask

    initial begin
        void'($urandom(81));
        clock        = 1'b0;
        resetn       = 1'b0;
        start_update = 1'b0;
        start_draw   = 1'b0;
        ant_id       = '0;
        load_en      = 1'b0;
        load_addr    = '0;
        load_data    = '0;
        repeat (2) @(posedge clock);
        #1;
        resetn = 1'b1;
        repeat (4) begin
            @(negedge clock);
            assert (finished && !start_dp && instruction_dp == '0)
                else report_error("outputs not idle after reset");
        end
        for (int s = 0; s < SCENARIOS; s++) begin
            // Kind 3 strobes both commands at once
            // Kind 4 strobes during a busy command
            make_scenario(s % 5);
            expected_step(exp_x, exp_y);
            snapshot_logs();
            run_command(1'b1, s % 5 == 3, s % 5 == 4);
            check_update();
            snapshot_logs();
            run_command(1'b0, 1'b1, s % 5 == 4);
            check_draw();
        end
        if (!protocol_error) begin
            $display("Result: PASSED");
            $finish;
        end else begin
            stop_failed();
        end
    end

endmodule

// ==== tb_datapath_model.sv ====
`timescale 1ns/1ps

module tb_datapath_model
    import dp_isa_pkg::*;
(
    input  logic       clock,
    input  logic       resetn,
    input  logic       start_dp,
    input  dp_instr_t  instruction_dp,
    input  logic       load_en,
    input  dp_addr_t   load_addr,
    input  dp_result_t load_data,
    output logic       finished_dp,
    output dp_result_t result_dp,
    output logic       protocol_error
);

    localparam int LOG_DEPTH = 512;

    dp_result_t mem [0:255];
    dp_instr_t  write_log [0:LOG_DEPTH-1];
    dp_instr_t  plot_log [0:LOG_DEPTH-1];
    int         write_count;
    int         plot_count;
    int         read_count;

    task automatic flag_error(input string msg);
        $display("error %0t: %s", $time, msg);
        protocol_error = 1'b1;
    endtask

    // Carries out one instruction and logs writes and plots
    task automatic execute(input dp_instr_t instr);
        dp_addr_t addr;
        addr = instr[10:3];
        case (instr[2:0])
            3'd1: begin
                result_dp = mem[addr];
                read_count++;
            end
            3'd2: begin
                mem[addr] = instr[26:11];
                write_log[write_count % LOG_DEPTH] = instr;
                write_count++;
            end
            3'd3: begin
                plot_log[plot_count % LOG_DEPTH] = instr;
                plot_count++;
            end
            default: flag_error($sformatf("unknown opcode %0d", instr[2:0]));
        endcase
    endtask

    // Called at the first falling edge that sees start high
    task automatic serve();
        dp_instr_t instr;
        int        delay;
        instr = instruction_dp;
        @(negedge clock);
        assert (start_dp && instruction_dp == instr)
            else flag_error("start_dp or instruction changed in the second start cycle");
        @(negedge clock);
        assert (!start_dp) else flag_error("start_dp high for more than two cycles");
        delay = $urandom_range(4, 1);
        repeat (delay - 1) begin
            @(negedge clock);
            assert (!start_dp && instruction_dp == instr)
                else flag_error("start_dp or instruction changed while waiting");
        end
        @(posedge clock);
        #1;
        execute(instr);
        finished_dp = 1'b1;
        @(negedge clock);
        assert (instruction_dp == instr)
            else flag_error("instruction changed in the finished cycle");
        @(posedge clock);
        #1;
        finished_dp = 1'b0;
    endtask

    initial begin
        finished_dp    = 1'b0;
        result_dp      = '0;
        protocol_error = 1'b0;
        write_count    = 0;
        plot_count     = 0;
        read_count     = 0;
        // Fill pattern built from all address bits
        for (int a = 0; a < 256; a++) begin
            mem[a] = dp_result_t'((a * 16'h0101) ^ 16'h5A3C);
        end
        forever begin
            @(negedge clock);
            if (load_en) begin
                mem[load_addr] = load_data;
            end else if (resetn && start_dp) begin
                serve();
            end
        end
    end

endmodule
